//--- src/lbp_pkg.sv
package lbp_pkg;

    localparam int PIX_W       = 8;
    localparam int WIN         = 5;
    localparam int NUM_SAMPLES = 8;
    localparam int PATCH_GAIN  = WIN * WIN;
    localparam int SUM_W       = 13;
    localparam int RIU_W       = 4;
    localparam int NON_UNIFORM = 9;

    // Sampling geometry around the window centre, angle k times 45 degrees.
    localparam int CENTRE  = WIN / 2;
    localparam int R_INNER = 1;
    localparam int R_OUTER = 2;
    localparam int DIR_ROW [NUM_SAMPLES] = '{0, -1, -1, -1, 0, 1, 1, 1};
    localparam int DIR_COL [NUM_SAMPLES] = '{1, 1, 0, -1, -1, -1, 0, 1};

    typedef logic [PIX_W-1:0]             pixel_t;
    typedef pixel_t [WIN-1:0][WIN-1:0]    window_t;  // Indexed [row][col].
    typedef pixel_t [NUM_SAMPLES-1:0]     ring_t;
    typedef logic [NUM_SAMPLES-1:0]       code_t;

    typedef struct packed {
        code_t code;
        logic  valid;
    } coded_t;

    typedef struct packed {
        logic [RIU_W-1:0] rd_label;
        logic [RIU_W-1:0] ni_label;
        logic             uniform_both;
    } joint_code_t;

    function automatic ring_t take_ring(window_t w, int radius);
        ring_t ring;
        for (int k = 0; k < NUM_SAMPLES; k++) begin
            ring[k] = w[CENTRE + radius * DIR_ROW[k]][CENTRE + radius * DIR_COL[k]];
        end
        return ring;
    endfunction

endpackage

//--- src/line_window.sv
`timescale 1ns/10ps

module line_window
    import lbp_pkg::*;
#(
    parameter int COLS = 30,
    parameter int ROWS = 30
) (
    input  logic    clk,
    input  logic    rst_i,
    input  pixel_t  pixel_i,
    input  logic    pixel_valid_i,
    output window_t window_o,
    output logic    window_valid_o
);

    localparam int COL_W = $clog2(COLS);
    localparam int ROW_W = $clog2(ROWS);
    localparam int LINES = WIN - 1;

    pixel_t           line_mem [LINES][COLS];
    pixel_t [WIN-1:0] new_col;
    window_t          win_q;
    logic [COL_W-1:0] col_cnt;
    logic [ROW_W-1:0] row_cnt;
    logic             valid_q;
    logic             last_col;
    logic             last_row;
    logic             full_window;

    assign last_col    = (col_cnt == COL_W'(COLS - 1));
    assign last_row    = (row_cnt == ROW_W'(ROWS - 1));
    assign full_window = (col_cnt >= COL_W'(WIN - 1)) && (row_cnt >= ROW_W'(WIN - 1));

    // Column entering the window, with the oldest line in element 0.
    always_comb begin
        for (int j = 0; j < LINES; j++) begin
            new_col[j] = line_mem[j][col_cnt];
        end
        new_col[LINES] = pixel_i;
    end

    // Every line moves up by one in the current column.
    always_ff @(posedge clk) begin
        if (pixel_valid_i) begin
            for (int j = 0; j < LINES; j++) begin
                line_mem[j][col_cnt] <= new_col[j + 1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pixel_valid_i) begin
            for (int r = 0; r < WIN; r++) begin
                for (int c = 0; c < WIN - 1; c++) begin
                    win_q[r][c] <= win_q[r][c + 1];  // Older columns slide left.
                end
                win_q[r][WIN-1] <= new_col[r];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            col_cnt <= '0;
            row_cnt <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= pixel_valid_i && full_window;
            if (pixel_valid_i) begin
                if (last_col) begin
                    col_cnt <= '0;
                    row_cnt <= last_row ? '0 : row_cnt + 1'b1;  // Wraps at frame end.
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    assign window_o       = win_q;
    assign window_valid_o = valid_q;

endmodule

//--- src/rd_coder.sv
`timescale 1ns/10ps

module rd_coder
    import lbp_pkg::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  window_t window_i,
    input  logic    window_valid_i,
    output coded_t  rd_o
);

    ring_t outer;
    ring_t inner;
    code_t code_d;
    code_t code_q;
    logic  valid_q;

    assign outer = take_ring(window_i, R_OUTER);
    assign inner = take_ring(window_i, R_INNER);

    // Bit k is set when the outer sample is not below the inner one.
    always_comb begin
        for (int k = 0; k < NUM_SAMPLES; k++) begin
            code_d[k] = (outer[k] >= inner[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= window_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (window_valid_i) begin
            code_q <= code_d;
        end
    end

    assign rd_o = '{code: code_q, valid: valid_q};

endmodule

//--- src/ni_coder.sv
`timescale 1ns/10ps

module ni_coder
    import lbp_pkg::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  window_t window_i,
    input  logic    window_valid_i,
    output coded_t  ni_o
);

    logic [SUM_W-1:0] row_sum [WIN];
    logic [SUM_W-1:0] patch_sum;
    logic [SUM_W-1:0] scaled [NUM_SAMPLES];
    ring_t            outer;
    code_t            code_d;
    code_t            code_q;
    logic             valid_q;

    // First level of the tree adds up each window row.
    always_comb begin
        for (int r = 0; r < WIN; r++) begin
            logic [SUM_W-1:0] acc;
            acc = '0;
            for (int c = 0; c < WIN; c++) begin
                acc = acc + SUM_W'(window_i[r][c]);
            end
            row_sum[r] = acc;
        end
    end

    assign patch_sum = (row_sum[0] + row_sum[1]) + (row_sum[2] + row_sum[3]) + row_sum[4];

    assign outer = take_ring(window_i, R_OUTER);

    // Sample times 25 against the sum is the same test as sample against the mean.
    always_comb begin
        for (int k = 0; k < NUM_SAMPLES; k++) begin
            scaled[k] = SUM_W'(outer[k]) * SUM_W'(PATCH_GAIN);
            code_d[k] = (scaled[k] >= patch_sum);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= window_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (window_valid_i) begin
            code_q <= code_d;
        end
    end

    assign ni_o = '{code: code_q, valid: valid_q};

endmodule

//--- src/riu2_joint.sv
`timescale 1ns/10ps

module riu2_joint
    import lbp_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    input  coded_t      rd_i,
    input  coded_t      ni_i,
    output joint_code_t code_o,
    output logic        code_valid_o
);

    logic [RIU_W-1:0] rd_label_d;
    logic [RIU_W-1:0] ni_label_d;
    logic [RIU_W-1:0] rd_label_q;
    logic [RIU_W-1:0] ni_label_q;
    logic             uniform_q;
    logic             valid_q;

    // Uniform patterns map to their count of ones, all others to one label.
    function automatic logic [RIU_W-1:0] riu2_label(code_t c);
        code_t rot;
        int    changes;
        rot     = {c[0], c[NUM_SAMPLES-1:1]};
        changes = $countones(c ^ rot);  // Includes the bit 7 to bit 0 step.
        if (changes <= 2) begin
            return RIU_W'($countones(c));
        end
        return RIU_W'(NON_UNIFORM);
    endfunction

    assign rd_label_d = riu2_label(rd_i.code);
    assign ni_label_d = riu2_label(ni_i.code);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= rd_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_i.valid) begin
            rd_label_q <= rd_label_d;
            uniform_q  <= (rd_label_d != RIU_W'(NON_UNIFORM)) &&
                          (ni_label_d != RIU_W'(NON_UNIFORM));
        end
        if (ni_i.valid) begin
            ni_label_q <= ni_label_d;
        end
    end

    assign code_o       = '{rd_label: rd_label_q, ni_label: ni_label_q, uniform_both: uniform_q};
    assign code_valid_o = valid_q;

endmodule

//--- src/lbp_texture.sv
`timescale 1ns/10ps

module lbp_texture
    import lbp_pkg::*;
#(
    parameter int COLS = 30,
    parameter int ROWS = 30
) (
    input  logic        clk,
    input  logic        rst_i,
    input  pixel_t      pixel_i,
    input  logic        pixel_valid_i,
    output joint_code_t code_o,
    output logic        code_valid_o
);

    window_t window;
    logic    window_valid;
    coded_t  rd;
    coded_t  ni;

    line_window #(
        .COLS (COLS),
        .ROWS (ROWS)
    ) u_line_window (
        .clk            (clk),
        .rst_i          (rst_i),
        .pixel_i        (pixel_i),
        .pixel_valid_i  (pixel_valid_i),
        .window_o       (window),
        .window_valid_o (window_valid)
    );

    // Both coders see the same window and stay cycle aligned.
    rd_coder u_rd_coder (
        .clk            (clk),
        .rst_i          (rst_i),
        .window_i       (window),
        .window_valid_i (window_valid),
        .rd_o           (rd)
    );

    ni_coder u_ni_coder (
        .clk            (clk),
        .rst_i          (rst_i),
        .window_i       (window),
        .window_valid_i (window_valid),
        .ni_o           (ni)
    );

    riu2_joint u_riu2_joint (
        .clk          (clk),
        .rst_i        (rst_i),
        .rd_i         (rd),
        .ni_i         (ni),
        .code_o       (code_o),
        .code_valid_o (code_valid_o)
    );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

//--- bench/lbp_texture_assert.sv
`timescale 1ns/10ps

module lbp_texture_assert
    import lbp_pkg::*;
#(
    parameter int COLS = 30,
    parameter int ROWS = 30
) (
    input logic        clk,
    input logic        rst_i,
    input logic        pixel_valid_i,
    input joint_code_t code_i,
    input logic        code_valid_i
);

    int   col_cnt;
    int   row_cnt;
    logic completes;

    // A pixel completes a window once four lines and four columns lie before it.
    assign completes = pixel_valid_i && (col_cnt >= WIN - 1) && (row_cnt >= WIN - 1);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            col_cnt <= 0;
            row_cnt <= 0;
        end else if (pixel_valid_i) begin
            if (col_cnt == COLS - 1) begin
                col_cnt <= 0;
                row_cnt <= (row_cnt == ROWS - 1) ? 0 : row_cnt + 1;
            end else begin
                col_cnt <= col_cnt + 1;
            end
        end
    end

    a_valid_low_in_reset: assert property (@(posedge clk) rst_i |=> !code_valid_i)
        else $error("code_valid_o still high one cycle into reset");

    // A code leaves three cycles after the pixel that completes its window.
    a_code_follows_pixel: assert property (@(posedge clk) disable iff (rst_i)
        code_valid_i == $past(completes, 3))
        else $error("code_valid_o does not follow a window-completing pixel by three cycles");

    a_label_range: assert property (@(posedge clk) disable iff (rst_i)
        code_valid_i |-> (code_i.rd_label <= RIU_W'(NON_UNIFORM)) &&
                         (code_i.ni_label <= RIU_W'(NON_UNIFORM)))
        else $error("label above the non-uniform label");

    a_uniform_flag: assert property (@(posedge clk) disable iff (rst_i)
        code_valid_i |-> code_i.uniform_both ==
            ((code_i.rd_label != RIU_W'(NON_UNIFORM)) && (code_i.ni_label != RIU_W'(NON_UNIFORM))))
        else $error("uniform_both disagrees with the two labels");

endmodule

bind lbp_texture lbp_texture_assert #(
    .COLS (COLS),
    .ROWS (ROWS)
) u_lbp_texture_assert (
    .clk           (clk),
    .rst_i         (rst_i),
    .pixel_valid_i (pixel_valid_i),
    .code_i        (code_o),
    .code_valid_i  (code_valid_o)
);

//--- bench/lbp_texture_tb.sv
`timescale 1ns/10ps

module lbp_texture_tb
    import lbp_pkg::*;
();

    localparam int COLS            = 8;
    localparam int ROWS            = 6;
    localparam int FRAME_PIX       = COLS * ROWS;
    localparam int CLK_PERIOD_NS   = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int DRAIN_LIMIT     = 16;
    localparam int NUM_TESTS       = 8;

    // Ring positions in window coordinates, row 0 and column 0 being the oldest.
    localparam int OUTER_ROW [8] = '{2, 0, 0, 0, 2, 4, 4, 4};
    localparam int OUTER_COL [8] = '{4, 4, 2, 0, 0, 0, 2, 4};
    localparam int INNER_ROW [8] = '{2, 1, 1, 1, 2, 3, 3, 3};
    localparam int INNER_COL [8] = '{3, 3, 2, 1, 1, 1, 2, 3};

    typedef enum int {PAT_CONST, PAT_HRAMP, PAT_VRAMP, PAT_CHECKER, PAT_RANDOM} pattern_e;

    typedef struct {
        pattern_e pattern;
        bit       gaps;
        int       pixels;       // Pixels sent, fewer than a frame when cut by reset.
        bit       reset_after;
    } test_row_t;

    test_row_t tests [NUM_TESTS] = '{
        '{PAT_CONST,   1'b0, FRAME_PIX, 1'b0},
        '{PAT_HRAMP,   1'b0, FRAME_PIX, 1'b0},
        '{PAT_VRAMP,   1'b1, FRAME_PIX, 1'b0},
        '{PAT_CHECKER, 1'b0, FRAME_PIX, 1'b0},
        '{PAT_RANDOM,  1'b1, FRAME_PIX, 1'b0},
        '{PAT_RANDOM,  1'b0, 30,        1'b1},
        '{PAT_HRAMP,   1'b1, FRAME_PIX, 1'b0},
        '{PAT_RANDOM,  1'b0, FRAME_PIX, 1'b0}
    };

    logic        clk;
    logic        rst_i;
    pixel_t      pixel_i;
    logic        pixel_valid_i;
    joint_code_t code_o;
    logic        code_valid_o;

    pixel_t      image [ROWS][COLS];
    joint_code_t exp_q [$];

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) u_clock (.clk_o(clk));

    lbp_texture #(
        .COLS (COLS),
        .ROWS (ROWS)
    ) dut (
        .clk           (clk),
        .rst_i         (rst_i),
        .pixel_i       (pixel_i),
        .pixel_valid_i (pixel_valid_i),
        .code_o        (code_o),
        .code_valid_o  (code_valid_o)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_label(input string name, input logic [RIU_W-1:0] got,
                               input logic [RIU_W-1:0] want);
        if (got !== want) begin
            abort_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    function automatic int uniform_label(input logic [7:0] code);
        int changes;
        int ones;
        changes = 0;
        ones    = 0;
        for (int k = 0; k < 8; k++) begin
            if (code[k] != code[(k + 1) % 8]) changes++;
            if (code[k]) ones++;
        end
        return (changes <= 2) ? ones : NON_UNIFORM;
    endfunction

    // Expected code for the window whose newest pixel sits at (row, col).
    function automatic joint_code_t model_code(input int row, input int col);
        int          sum;
        int          outer;
        int          inner;
        int          rd_lab;
        int          ni_lab;
        logic [7:0]  rd_bits;
        logic [7:0]  ni_bits;
        joint_code_t jc;
        sum = 0;
        for (int r = 0; r < 5; r++) begin
            for (int c = 0; c < 5; c++) begin
                sum += int'(image[row - 4 + r][col - 4 + c]);
            end
        end
        for (int k = 0; k < 8; k++) begin
            outer      = int'(image[row - 4 + OUTER_ROW[k]][col - 4 + OUTER_COL[k]]);
            inner      = int'(image[row - 4 + INNER_ROW[k]][col - 4 + INNER_COL[k]]);
            rd_bits[k] = (outer >= inner);
            ni_bits[k] = (outer * PATCH_GAIN >= sum);  // Sample against the patch mean.
        end
        rd_lab          = uniform_label(rd_bits);
        ni_lab          = uniform_label(ni_bits);
        jc.rd_label     = RIU_W'(rd_lab);
        jc.ni_label     = RIU_W'(ni_lab);
        jc.uniform_both = (rd_lab != NON_UNIFORM) && (ni_lab != NON_UNIFORM);
        return jc;
    endfunction

    task automatic fill_image(input pattern_e pat);
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                case (pat)
                    PAT_CONST:   image[r][c] = 8'h6C;
                    PAT_HRAMP:   image[r][c] = pixel_t'(c * 29 + 3);
                    PAT_VRAMP:   image[r][c] = pixel_t'(r * 37 + 11);
                    PAT_CHECKER: image[r][c] = ((r + c) % 2 == 1) ? 8'hE0 : 8'h20;
                    default:     image[r][c] = pixel_t'($urandom);
                endcase
            end
        end
    endtask

    task automatic send_pixel(input pixel_t value, input int gap);
        repeat (gap) begin
            @(posedge clk);
            #1;
            pixel_valid_i = 1'b0;
        end
        @(posedge clk);
        #1;
        pixel_i       = value;
        pixel_valid_i = 1'b1;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        pixel_valid_i = 1'b0;
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge clk);
        #1;
        rst_i = 1'b1;
        repeat (cycles) @(posedge clk);
        #1;
        rst_i = 1'b0;
    endtask

    task automatic wait_for_codes();
        int idle;
        idle = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            idle++;
            if (idle > DRAIN_LIMIT) begin
                abort_run($sformatf("Still waiting for %0d codes, code_valid_o stayed low",
                                    exp_q.size()));
            end
        end
        repeat (4) @(posedge clk);  // Room for a stray code to show up.
    endtask

    task automatic run_frame(input test_row_t t);
        int gap;
        int r;
        int c;
        fill_image(t.pattern);
        for (int i = 0; i < t.pixels; i++) begin
            r = i / COLS;
            c = i % COLS;
            if (r >= 4 && c >= 4) exp_q.push_back(model_code(r, c));
            gap = t.gaps ? int'($urandom_range(3, 0)) : 0;
            send_pixel(image[r][c], gap);
        end
        idle_cycle();
        if (t.reset_after) apply_reset(RESET_CYCLES);
        wait_for_codes();
    endtask

    // Outputs are registered on the rising edge, so they are sampled on the falling one.
    initial begin
        joint_code_t want;
        forever begin
            @(negedge clk);
            if (code_valid_o === 1'b1) begin
                if (exp_q.size() == 0) begin
                    abort_run("code_valid_o pulsed while no code was expected");
                end
                want = exp_q.pop_front();
                check_label("code_o.rd_label", code_o.rd_label, want.rd_label);
                check_label("code_o.ni_label", code_o.ni_label, want.ni_label);
                check_flag("code_o.uniform_both", code_o.uniform_both, want.uniform_both);
            end
        end
    end

    initial begin
        int cycles;
        cycles = RESET_CYCLES;
        for (int t = 0; t < NUM_TESTS; t++) begin
            cycles += 20 * tests[t].pixels;
            if (tests[t].reset_after) cycles += RESET_CYCLES;
        end
        #(cycles * CLK_PERIOD_NS);
        $display("Watchdog expired after %0d cycles before the run finished", cycles);
        $display("Regression failed");
        $fatal(1, "Timeout");
    end

    initial begin
        rst_i         = 1'b1;
        pixel_i       = '0;
        pixel_valid_i = 1'b0;
        void'($urandom(18750));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_i = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_frame(tests[t]);
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected codes never arrived", exp_q.size());
            $display("Regression failed");
            $fatal(1, "Missing codes");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

//--- lbp_texture.f
src/lbp_pkg.sv
src/line_window.sv
src/rd_coder.sv
src/ni_coder.sv
src/riu2_joint.sv
src/lbp_texture.sv
bench/tb_clock.sv
bench/lbp_texture_assert.sv
bench/lbp_texture_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := lbp_texture_tb
FILELIST  := lbp_texture.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Regression failed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation did not pass, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
